/* flist.f */
src/eth_types_pkg.sv
src/eth_cfg_pkg.sv
src/tx_byte_fifo.sv
src/eth_crc32.sv
src/gmii_tx_framer.sv
src/gmii_symbol_out.sv
src/eth_tx_top.sv
testbench/eth_tx_checker.sv
testbench/eth_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the transmit path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module eth_tx_tb -f flist.f -o eth_tx_sim \
    && ./obj_dir/eth_tx_sim > sim.log 2>&1
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/eth_tx_tb.sv */
// Ethernet transmit path testbench with stimulus, expected frames,
// output monitor, FIFO occupancy model, watchdog and result line
`default_nettype none

module eth_tx_tb;

    localparam int IFG = 12;

    logic                    clk;
    logic                    reset_crc;
    eth_types_pkg::tx_beat_t in_beat;
    logic                    in_valid;
    logic                    in_ready;
    eth_types_pkg::gap_t     ifg_delay;
    logic                    clk_enable;
    logic                    mii_select;
    eth_types_pkg::byte_t    gmii_txd;
    logic                    gmii_tx_en;
    logic                    gmii_tx_er;

    logic [15:0]          lfsr_q = 16'd78;
    eth_types_pkg::byte_t payload[$];
    eth_types_pkg::byte_t saved[$];
    eth_types_pkg::byte_t exp_data[$];
    int                   exp_len[$];
    bit                   exp_er[$];
    eth_types_pkg::byte_t got[$];
    bit                   got_er;
    bit                   in_frame;
    bit                   half;
    logic [3:0]           lo_nib;
    int                   idle_slots;
    int                   frames_seen;
    int                   frames_expected;
    bit                   prev_ce;
    int                   occ;
    bit                   full_seen;
    bit                   ce_random;
    int                   errors;
    int                   checks;

    eth_tx_top dut (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .ifg_delay  (ifg_delay),
        .clk_enable (clk_enable),
        .mii_select (mii_select),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic bit lfsr_bit();
        bit fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic eth_types_pkg::byte_t rand_byte();
        eth_types_pkg::byte_t b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    // CRC-32 over 0x04C11DB7 in msb-first form
    // data bits enter lsb first and the result is bit-reversed and complemented
    function automatic logic [31:0] fcs_of(input eth_types_pkg::byte_t body[$]);
        logic [31:0] c;
        logic [31:0] r;
        bit          fb;
        c = 32'hFFFFFFFF;
        foreach (body[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[31] ^ body[i][b];
                c  = {c[30:0], 1'b0};
                if (fb) c = c ^ 32'h04C11DB7;
            end
        end
        for (int k = 0; k < 32; k++) begin
            r[k] = c[31 - k];
        end
        return ~r;
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic new_payload(input int n);
        payload = {};
        repeat (n) payload.push_back(rand_byte());
    endtask

    // expected wire bytes for the first n payload bytes
    task automatic expect_frame(input int n, input bit full, input bit er);
        eth_types_pkg::byte_t body[$];
        logic [31:0]          fcs;
        body = {};
        for (int i = 0; i < n; i++) begin
            body.push_back(payload[i]);
        end
        if (full) begin
            while (body.size() < 60) body.push_back(8'h00);
        end
        fcs = fcs_of(body);
        repeat (7) exp_data.push_back(8'h55);
        exp_data.push_back(8'hD5);
        foreach (body[i]) exp_data.push_back(body[i]);
        if (full) begin
            for (int k = 0; k < 4; k++) exp_data.push_back(fcs[8*k +: 8]);
        end
        exp_len.push_back(8 + body.size() + (full ? 4 : 0));
        exp_er.push_back(er);
        frames_expected++;
    endtask

    task automatic send_range(input int from, input int to, input bit mark_last,
                              input bit user, input bit stalls);
        int idx;
        bit stall;
        idx = from;
        while (idx <= to) begin
            @(posedge clk);
            stall = 1'b0;
            if (stalls) begin
                stall = lfsr_bit();
                stall = stall & lfsr_bit();
            end
            in_valid <= !stall;
            in_beat  <= '{data: payload[idx], last: mark_last && idx == to,
                          user: user && idx == to};
            @(negedge clk);
            if (!stall && in_ready) begin
                idx++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic settle();
        wait (frames_seen == frames_expected);
        repeat (40) @(posedge clk);
    endtask

    task automatic close_frame();
        int n;
        int mism;
        bit er;
        eth_types_pkg::byte_t eb;
        mism = 0;
        if (exp_len.size() == 0) begin
            check(1'b0, "frame seen with none expected");
        end else begin
            n  = exp_len.pop_front();
            er = exp_er.pop_front();
            check(got.size() == n, $sformatf("frame %0d has %0d bytes, expected %0d",
                                             frames_seen, got.size(), n));
            for (int i = 0; i < n; i++) begin
                eb = exp_data.pop_front();
                if (i >= got.size() || got[i] != eb) mism++;
            end
            check(mism == 0, $sformatf("frame %0d has %0d wrong bytes", frames_seen, mism));
            check(got_er == er, $sformatf("frame %0d tx_er %0b, expected %0b",
                                          frames_seen, got_er, er));
        end
        frames_seen++;
        got    = {};
        got_er = 1'b0;
    endtask

    // outputs change only after an edge where clk_enable was high
    always @(negedge clk) begin
        if (!reset_crc && prev_ce) begin
            if (gmii_tx_en) begin
                if (!in_frame && frames_seen > 0) begin
                    check((mii_select ? idle_slots / 2 : idle_slots) >= IFG,
                          "inter-frame gap shorter than ifg_delay");
                end
                in_frame = 1'b1;
                if (gmii_tx_er) got_er = 1'b1;
                if (!mii_select) begin
                    got.push_back(gmii_txd);
                end else if (!half) begin
                    lo_nib = gmii_txd[3:0];
                    half   = 1'b1;
                end else begin
                    got.push_back({gmii_txd[3:0], lo_nib});
                    half = 1'b0;
                end
            end else begin
                if (in_frame) close_frame();
                in_frame = 1'b0;
                half     = 1'b0;
                idle_slots++;
            end
            if (gmii_tx_en) idle_slots = 0;
        end
        prev_ce = clk_enable;
    end

    // occupancy from accepted beats and framer pops
    always @(negedge clk) begin
        if (reset_crc) begin
            occ = 0;
        end else begin
            check(in_ready == (occ < 16), $sformatf("in_ready %0b with %0d beats held",
                                                    in_ready, occ));
            if (!in_ready) full_seen = 1'b1;
            if (in_valid && in_ready) occ++;
            if (dut.fifo_pop) occ--;
        end
    end

    always @(posedge clk) begin
        if (ce_random) begin
            clk_enable <= lfsr_bit();
        end else begin
            clk_enable <= 1'b1;
        end
    end

    initial begin
        int    lens[8];
        longint slots;
        lens  = '{20, 100, 30, 30, 10, 8, 20, 30};
        slots = 0;
        foreach (lens[i]) slots += 8 + ((lens[i] < 60) ? 60 : lens[i]) + 4 + IFG + 40;
        // nibble mode doubles the time and random enable roughly halves the rate
        #(slots * 2 * 4 * 100);
        $display("timeout: frames did not finish within the watchdog limit");
        $display("sim failed");
        $finish;
    end

    initial begin
        in_beat    = '0;
        in_valid   = 1'b0;
        ifg_delay  = 8'(IFG);
        clk_enable = 1'b1;
        mii_select = 1'b0;
        reset_crc  = 1'b1;
        repeat (2) @(posedge clk);
        reset_crc <= 1'b0;

        // short frame padded to 60 bytes
        new_payload(20);
        saved = payload;
        expect_frame(20, 1'b1, 1'b0);
        send_range(0, 19, 1'b1, 1'b0, 1'b0);
        settle();

        // long frame with input stalls under MII pacing so the FIFO fills
        mii_select <= 1'b1;
        new_payload(100);
        expect_frame(100, 1'b1, 1'b0);
        send_range(0, 99, 1'b1, 1'b0, 1'b1);
        settle();
        check(full_seen, "in_ready never fell during the long frame");

        // two frames back to back
        mii_select <= 1'b0;
        new_payload(30);
        expect_frame(30, 1'b1, 1'b0);
        send_range(0, 29, 1'b1, 1'b0, 1'b0);
        new_payload(30);
        expect_frame(30, 1'b1, 1'b0);
        send_range(0, 29, 1'b1, 1'b0, 1'b0);
        settle();

        // error flag on the last beat and no FCS
        new_payload(10);
        expect_frame(10, 1'b0, 1'b1);
        send_range(0, 9, 1'b1, 1'b1, 1'b0);
        settle();

        // underflow after 3 beats drops the remainder
        new_payload(8);
        expect_frame(3, 1'b0, 1'b1);
        send_range(0, 2, 1'b0, 1'b0, 1'b0);
        settle();
        send_range(3, 7, 1'b1, 1'b0, 1'b0);
        repeat (40) @(posedge clk);

        // first frame again in MII mode
        mii_select <= 1'b1;
        payload = saved;
        expect_frame(20, 1'b1, 1'b0);
        send_range(0, 19, 1'b1, 1'b0, 1'b0);
        settle();

        // random clock enable
        mii_select <= 1'b0;
        new_payload(30);
        expect_frame(30, 1'b1, 1'b0);
        @(negedge clk);
        ce_random = 1'b1;
        send_range(0, 29, 1'b1, 1'b0, 1'b0);
        wait (frames_seen == frames_expected);
        @(negedge clk);
        ce_random = 1'b0;
        settle();

        check(exp_len.size() == 0, "expected frames never appeared");
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/eth_tx_checker.sv */
// protocol assertions for the transmit path, bound to eth_tx_top
`default_nettype none

module eth_tx_checker (
    input logic                 clk,
    input logic                 reset_crc,
    input logic                 clk_enable,
    input logic                 mii_select,
    input eth_types_pkg::byte_t gmii_txd,
    input logic                 gmii_tx_en,
    input logic                 gmii_tx_er,
    input logic                 fifo_pop,
    input logic                 fifo_valid
);

    er_needs_en: assert property (@(posedge clk) gmii_tx_er |-> gmii_tx_en)
        else $error("tx_er high while tx_en is low");

    idle_after_reset: assert property (@(posedge clk)
        reset_crc |=> (!gmii_tx_en && !gmii_tx_er && gmii_txd == 8'd0))
        else $error("outputs not cleared after reset");

    // upper nibble unused in MII mode
    mii_upper_zero: assert property (@(posedge clk) disable iff (reset_crc)
        (mii_select && clk_enable) |=> gmii_txd[7:4] == 4'd0)
        else $error("txd bits 7 to 4 set in MII mode");

    hold_when_disabled: assert property (@(posedge clk) disable iff (reset_crc)
        (!clk_enable && !reset_crc) |=>
            ($stable(gmii_txd) && $stable(gmii_tx_en) && $stable(gmii_tx_er)))
        else $error("outputs moved while clk_enable was low");

    pop_needs_valid: assert property (@(posedge clk) fifo_pop |-> fifo_valid)
        else $error("FIFO popped while empty");

endmodule

bind eth_tx_top eth_tx_checker u_checker (
    .clk        (clk),
    .reset_crc  (reset_crc),
    .clk_enable (clk_enable),
    .mii_select (mii_select),
    .gmii_txd   (gmii_txd),
    .gmii_tx_en (gmii_tx_en),
    .gmii_tx_er (gmii_tx_er),
    .fifo_pop   (fifo_pop),
    .fifo_valid (fifo_valid)
);

`default_nettype wire

/* src/eth_tx_top.sv */
// Ethernet transmit path top: input FIFO, framer, symbol output stage
`default_nettype none

module eth_tx_top (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  eth_types_pkg::tx_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  eth_types_pkg::gap_t     ifg_delay,
    input  logic                    clk_enable,
    input  logic                    mii_select,
    output eth_types_pkg::byte_t    gmii_txd,
    output logic                    gmii_tx_en,
    output logic                    gmii_tx_er
);

    eth_types_pkg::tx_beat_t  fifo_beat;
    logic                     fifo_valid;
    logic                     fifo_pop;
    logic                     advance;
    eth_types_pkg::gmii_sym_t sym;

    tx_byte_fifo u_fifo (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_pop   (fifo_pop)
    );

    gmii_tx_framer u_framer (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_pop   (fifo_pop),
        .advance    (advance),
        .ifg_delay  (ifg_delay),
        .sym        (sym)
    );

    gmii_symbol_out u_sym_out (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .sym        (sym),
        .clk_enable (clk_enable),
        .mii_select (mii_select),
        .advance    (advance),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

endmodule

`default_nettype wire

/* src/gmii_symbol_out.sv */
// output register for GMII symbols
// clock-enable hold and MII low/high nibble split
`default_nettype none

module gmii_symbol_out (
    input  logic                     clk,
    input  logic                     reset_crc,
    input  eth_types_pkg::gmii_sym_t sym,
    input  logic                     clk_enable,
    input  logic                     mii_select,
    output logic                     advance,
    output eth_types_pkg::byte_t     gmii_txd,
    output logic                     gmii_tx_en,
    output logic                     gmii_tx_er
);

    // high nibble still to be sent in MII mode
    logic       odd;
    logic [3:0] msn;

    assign advance = clk_enable && !(mii_select && odd);

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            odd        <= 1'b0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else if (clk_enable) begin
            if (mii_select && odd) begin
                // second nibble, en/er kept from the first
                gmii_txd <= {4'd0, msn};
                odd      <= 1'b0;
            end else begin
                gmii_tx_en <= sym.en;
                gmii_tx_er <= sym.er;
                if (mii_select) begin
                    gmii_txd <= {4'd0, sym.data[3:0]};
                    odd      <= 1'b1;
                end else begin
                    gmii_txd <= sym.data;
                    odd      <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            msn <= sym.data[7:4];
        end
    end

endmodule

`default_nettype wire

/* src/gmii_tx_framer.sv */
// transmit framer FSM: preamble, SFD, payload, pad, FCS, gap
// one symbol per advance, CRC via eth_crc32
`default_nettype none

module gmii_tx_framer (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  eth_types_pkg::tx_beat_t   fifo_beat,
    input  logic                      fifo_valid,
    output logic                      fifo_pop,
    input  logic                      advance,
    input  eth_types_pkg::gap_t       ifg_delay,
    output eth_types_pkg::gmii_sym_t  sym
);

    eth_types_pkg::framer_state_t state;
    eth_types_pkg::framer_state_t state_next;

    logic [15:0] ptr;
    logic [15:0] ptr_next;
    logic [15:0] ptr_inc;

    eth_types_pkg::crc_t crc;
    eth_types_pkg::crc_t crc_next;

    // byte held between FIFO pop and its transmit slot
    eth_types_pkg::byte_t data_q;
    logic                 user_q;

    logic pop_req;
    logic crc_clear;
    logic crc_update;

    assign ptr_inc  = ptr + 16'd1;
    assign fifo_pop = advance && pop_req;

    eth_crc32 u_crc (
        .data    (sym.data),
        .crc_in  (crc),
        .crc_out (crc_next)
    );

    always_comb begin
        state_next = state;
        ptr_next   = ptr_inc;
        pop_req    = 1'b0;
        crc_clear  = 1'b0;
        crc_update = 1'b0;
        sym        = '0;

        case (state)
            eth_types_pkg::idle: begin
                crc_clear = 1'b1;
                ptr_next  = ptr;
                if (fifo_valid) begin
                    sym.data   = eth_cfg_pkg::PREAMBLE_BYTE;
                    sym.en     = 1'b1;
                    ptr_next   = 16'd1;
                    state_next = eth_types_pkg::preamble;
                end
            end
            eth_types_pkg::preamble: begin
                crc_clear = 1'b1;
                sym.en    = 1'b1;
                if (ptr == eth_cfg_pkg::PREAMBLE_LEN) begin
                    // SFD slot, first payload byte leaves the FIFO
                    sym.data = eth_cfg_pkg::SFD_BYTE;
                    pop_req  = fifo_valid;
                    ptr_next = 16'd0;
                    state_next = fifo_beat.last ? eth_types_pkg::last
                                                : eth_types_pkg::payload;
                end else begin
                    sym.data = eth_cfg_pkg::PREAMBLE_BYTE;
                end
            end
            eth_types_pkg::payload: begin
                crc_update = 1'b1;
                sym.data   = data_q;
                sym.en     = 1'b1;
                if (fifo_valid) begin
                    pop_req    = 1'b1;
                    state_next = fifo_beat.last ? eth_types_pkg::last
                                                : eth_types_pkg::payload;
                end else begin
                    // underflow mid-frame
                    sym.er     = 1'b1;
                    state_next = eth_types_pkg::wait_end;
                end
            end
            eth_types_pkg::last: begin
                crc_update = 1'b1;
                sym.data   = data_q;
                sym.en     = 1'b1;
                sym.er     = user_q;
                if (user_q) begin
                    ptr_next   = 16'd0;
                    state_next = eth_types_pkg::ifg;
                end else if (ptr_inc < eth_cfg_pkg::MIN_FRAME_LEN - 16'd4) begin
                    state_next = eth_types_pkg::pad;
                end else begin
                    ptr_next   = 16'd0;
                    state_next = eth_types_pkg::fcs;
                end
            end
            eth_types_pkg::pad: begin
                crc_update = 1'b1;
                sym.en     = 1'b1;
                if (!(ptr_inc < eth_cfg_pkg::MIN_FRAME_LEN - 16'd4)) begin
                    ptr_next   = 16'd0;
                    state_next = eth_types_pkg::fcs;
                end
            end
            eth_types_pkg::fcs: begin
                // low byte first, complemented
                sym.data = ~crc[{ptr[1:0], 3'b000} +: 8];
                sym.en   = 1'b1;
                if (ptr[1:0] == 2'd3) begin
                    ptr_next   = 16'd0;
                    state_next = eth_types_pkg::ifg;
                end
            end
            eth_types_pkg::wait_end: begin
                crc_clear = 1'b1;
                ptr_next  = 16'd0;
                // drop the rest of the failed frame
                if (fifo_valid) begin
                    pop_req = 1'b1;
                    if (fifo_beat.last) begin
                        state_next = eth_types_pkg::ifg;
                    end
                end
            end
            eth_types_pkg::ifg: begin
                crc_clear = 1'b1;
                if (!(ptr_inc < {8'd0, ifg_delay})) begin
                    ptr_next   = 16'd0;
                    state_next = eth_types_pkg::idle;
                end
            end
            default: begin
                state_next = eth_types_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= eth_types_pkg::idle;
            ptr   <= 16'd0;
            crc   <= eth_cfg_pkg::CRC_INIT;
        end else if (advance) begin
            state <= state_next;
            ptr   <= ptr_next;
            if (crc_clear) begin
                crc <= eth_cfg_pkg::CRC_INIT;
            end else if (crc_update) begin
                crc <= crc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            data_q <= fifo_beat.data;
            user_q <= fifo_beat.user;
        end
    end

endmodule

`default_nettype wire

/* src/eth_crc32.sv */
// byte-wide Ethernet CRC-32 step, no state
`default_nettype none

module eth_crc32 (
    input  eth_types_pkg::byte_t data,
    input  eth_types_pkg::crc_t  crc_in,
    output eth_types_pkg::crc_t  crc_out
);

    // eight reflected shift/xor steps, lsb of the byte first
    always_comb begin
        eth_types_pkg::crc_t c;

        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ eth_cfg_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        crc_out = c;
    end

endmodule

`default_nettype wire

/* src/tx_byte_fifo.sv */
// input byte FIFO in front of the framer
// circular buffer with registered pointers and occupancy count
`default_nettype none

module tx_byte_fifo (
    input  logic                   clk,
    input  logic                   reset_crc,
    input  eth_types_pkg::tx_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output eth_types_pkg::tx_beat_t fifo_beat,
    output logic                   fifo_valid,
    input  logic                   fifo_pop
);

    eth_types_pkg::tx_beat_t mem [0:eth_cfg_pkg::FIFO_DEPTH-1];

    logic [eth_cfg_pkg::FIFO_AW-1:0] wr_ptr;
    logic [eth_cfg_pkg::FIFO_AW-1:0] rd_ptr;
    logic [eth_cfg_pkg::FIFO_AW:0]   count;

    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop  = fifo_pop && fifo_valid;

    // full only when every entry is taken
    assign in_ready   = (count != eth_cfg_pkg::FIFO_DEPTH);
    assign fifo_valid = (count != '0);
    assign fifo_beat  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + (eth_cfg_pkg::FIFO_AW)'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + (eth_cfg_pkg::FIFO_AW)'(1);
            end
            // count moves only when exactly one side is active
            if (push && !pop) begin
                count <= count + (eth_cfg_pkg::FIFO_AW + 1)'(1);
            end else if (pop && !push) begin
                count <= count - (eth_cfg_pkg::FIFO_AW + 1)'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* src/eth_cfg_pkg.sv */
// Ethernet framing constants, CRC-32 polynomial and seed,
// input FIFO sizing
`default_nettype none

package eth_cfg_pkg;

    // preamble and start-of-frame delimiter
    localparam eth_types_pkg::byte_t PREAMBLE_BYTE = 8'h55;
    localparam eth_types_pkg::byte_t SFD_BYTE      = 8'hD5;
    localparam logic [15:0]          PREAMBLE_LEN  = 16'd7;

    // minimum frame length, FCS included
    localparam logic [15:0] MIN_FRAME_LEN = 16'd64;

    // bit-reversed form of 0x04C11DB7
    localparam eth_types_pkg::crc_t CRC_POLY = 32'hEDB88320;
    localparam eth_types_pkg::crc_t CRC_INIT = 32'hFFFFFFFF;

    // input FIFO, depth is 2**FIFO_AW
    localparam int unsigned         FIFO_AW    = 4;
    localparam logic [FIFO_AW:0]    FIFO_DEPTH = 5'd16;

endpackage

`default_nettype wire

/* src/eth_types_pkg.sv */
// shared transmit-path types: byte, CRC and gap vectors,
// stream beat and GMII symbol structs, framer state encoding
`default_nettype none

package eth_types_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;
    // gap length counted in byte times
    typedef logic [7:0]  gap_t;

    // one byte of the incoming frame stream
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } tx_beat_t;

    // one GMII transmit symbol
    typedef struct packed {
        byte_t data;
        logic  en;
        logic  er;
    } gmii_sym_t;

    typedef enum logic [2:0] {
        idle,
        preamble,
        payload,
        last,
        pad,
        fcs,
        wait_end,
        ifg
    } framer_state_t;

endpackage

`default_nettype wire
